// File: common/lpddr4_cfg.svh
`ifndef LPDDR4_CFG_SVH
`define LPDDR4_CFG_SVH

// CA bus, CA0 is bit 0
`define LPDDR4_CA_W 6

`define LPDDR4_BANKS 8

`define LPDDR4_ROW_W 16

// column bits C9 to C2
`define LPDDR4_COL_W 8

`define LPDDR4_MR_W 8

// latency = base + step * code
`define LPDDR4_LAT_BASE 6

`define LPDDR4_LAT_STEP 4

`endif

// File: common/lpddr4_pkg.sv
`include "lpddr4_cfg.svh"

package lpddr4_pkg;

    typedef logic [`LPDDR4_CA_W-1:0] ca_word_t;
    typedef logic [$clog2(`LPDDR4_BANKS)-1:0] bank_t;
    typedef logic [`LPDDR4_BANKS-1:0] bank_map_t;
    typedef logic [`LPDDR4_ROW_W-1:0] row_t;
    typedef logic [`LPDDR4_COL_W-1:0] col_t;
    typedef logic [`LPDDR4_CA_W-1:0] mr_addr_t;
    typedef logic [`LPDDR4_MR_W-1:0] mr_data_t;
    typedef logic [5:0] lat_t; // clock cycles

    typedef enum logic [3:0] {
        CMD_MPC,
        CMD_PRE,
        CMD_REF,
        CMD_SRE,
        CMD_SRX,
        CMD_WR,
        CMD_MWR,
        CMD_RD,
        CMD_MRW,
        CMD_MRR,
        CMD_ACT,
        CMD_RFU
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t kind;
        ca_word_t  r1;
        ca_word_t  r2;
        ca_word_t  r3; // zero for two-word frames
        ca_word_t  r4;
    } ca_frame_t;

    typedef struct packed {
        cmd_kind_t             kind;
        bank_t                 bank;
        logic                  all_banks;
        logic                  auto_pre;
        row_t                  row;
        col_t                  column;
        mr_addr_t              mr_addr;
        mr_data_t              mr_data;
        logic [`LPDDR4_CA_W:0] mpc_op;
    } dec_cmd_t;

    typedef struct packed {
        mr_data_t   mr0; // raw byte
        lat_t       read_latency;
        lat_t       write_latency;
        lat_t       nwr;
        logic [1:0] burst_len;
        logic       wls;
        logic       wr_lev;
    } mr_cfg_t;

endpackage

// File: ca_capture/ca_frame_capture.sv
`timescale 1ns/1ps
`include "lpddr4_cfg.svh"

module ca_frame_capture (
    input  logic                  ck_t,
    input  logic                  reset,
    input  logic                  cs,
    input  lpddr4_pkg::ca_word_t  ca,
    output logic                  frame_valid,
    output lpddr4_pkg::ca_frame_t frame
);

    localparam int CA5 = `LPDDR4_CA_W - 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_W2,
        ST_W3,
        ST_W4
    } cap_state_t;

    cap_state_t            state;
    lpddr4_pkg::ca_word_t  w1;
    lpddr4_pkg::ca_word_t  w2;
    lpddr4_pkg::ca_word_t  w3;
    lpddr4_pkg::cmd_kind_t kind;
    logic                  four_word;

    // command code is CA0 (msb) through CA4 of r1
    function automatic lpddr4_pkg::cmd_kind_t classify(input lpddr4_pkg::ca_word_t w);
        logic [4:0] code;
        code = {w[0], w[1], w[2], w[3], w[4]};
        casez (code)
            5'b00000: classify = lpddr4_pkg::CMD_MPC;
            5'b00001: classify = lpddr4_pkg::CMD_PRE;
            5'b00010: classify = lpddr4_pkg::CMD_REF;
            5'b00011: classify = lpddr4_pkg::CMD_SRE;
            5'b00100: classify = lpddr4_pkg::CMD_WR;
            5'b00101: classify = lpddr4_pkg::CMD_SRX;
            5'b00110: classify = lpddr4_pkg::CMD_MWR;
            5'b01000: classify = lpddr4_pkg::CMD_RD;
            5'b01100: classify = lpddr4_pkg::CMD_MRW;
            5'b01110: classify = lpddr4_pkg::CMD_MRR;
            5'b10???: classify = lpddr4_pkg::CMD_ACT;
            default:  classify = lpddr4_pkg::CMD_RFU;
        endcase
    endfunction

    assign kind = classify(w1);

    // length decided in ST_W2, where ca holds r2
    always_comb begin
        case (kind)
            lpddr4_pkg::CMD_WR,
            lpddr4_pkg::CMD_MWR,
            lpddr4_pkg::CMD_RD,
            lpddr4_pkg::CMD_MRR,
            lpddr4_pkg::CMD_MRW,
            lpddr4_pkg::CMD_ACT: four_word = 1'b1;
            lpddr4_pkg::CMD_MPC: four_word = w1[CA5] &&
                (ca == 6'b000111 || ca == 6'b000001 || ca == 6'b000011); // fifo / dq cal
            default:             four_word = 1'b0;
        endcase
    end

    always_ff @(posedge ck_t) begin
        if (reset) begin
            state       <= ST_IDLE;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                ST_IDLE: if (cs) state <= ST_W2;
                ST_W2: begin
                    if (four_word) begin
                        state <= ST_W3;
                    end else begin
                        state       <= ST_IDLE;
                        frame_valid <= 1'b1;
                    end
                end
                ST_W3: state <= ST_W4;
                ST_W4: begin
                    state       <= ST_IDLE;
                    frame_valid <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge ck_t) begin
        case (state)
            ST_IDLE: if (cs) w1 <= ca;
            ST_W2: begin
                w2 <= ca;
                if (!four_word) frame <= '{kind: kind, r1: w1, r2: ca, r3: '0, r4: '0};
            end
            ST_W3: w3 <= ca;
            ST_W4: frame <= '{kind: kind, r1: w1, r2: w2, r3: w3, r4: ca};
        endcase
    end

endmodule

// File: hw/cmd_field_extract.sv
`timescale 1ns/1ps
`include "lpddr4_cfg.svh"

module cmd_field_extract (
    input  logic                  ck_t,
    input  logic                  reset,
    input  logic                  frame_valid,
    input  lpddr4_pkg::ca_frame_t frame,
    output logic                  cmd_valid,
    output lpddr4_pkg::dec_cmd_t  cmd
);

    localparam int CA5 = `LPDDR4_CA_W - 1;

    lpddr4_pkg::dec_cmd_t dec;

    always_comb begin
        dec      = '0; // unused fields stay zero
        dec.kind = frame.kind;
        case (frame.kind)
            lpddr4_pkg::CMD_PRE,
            lpddr4_pkg::CMD_REF: begin
                dec.bank      = frame.r2[2:0];
                dec.all_banks = frame.r1[CA5];
            end
            lpddr4_pkg::CMD_WR,
            lpddr4_pkg::CMD_MWR,
            lpddr4_pkg::CMD_RD: begin
                dec.bank     = frame.r2[2:0];
                dec.auto_pre = frame.r2[CA5]; // high means auto-precharge
                dec.column   = {frame.r2[4], frame.r3[CA5], frame.r4};
            end
            lpddr4_pkg::CMD_ACT: begin
                dec.bank = frame.r2[2:0];
                dec.row  = {frame.r1[CA5:2], frame.r2[CA5:4], frame.r3[CA5:2], frame.r4};
            end
            lpddr4_pkg::CMD_MRW: begin
                dec.mr_addr = frame.r2;
                dec.mr_data = {frame.r1[CA5], frame.r3[CA5], frame.r4};
            end
            lpddr4_pkg::CMD_MRR: dec.mr_addr = frame.r2;
            lpddr4_pkg::CMD_MPC: dec.mpc_op = {frame.r1[CA5], frame.r2};
            default: ; // kind only
        endcase
    end

    always_ff @(posedge ck_t) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= frame_valid;
        end
    end

    always_ff @(posedge ck_t) begin
        if (frame_valid) cmd <= dec;
    end

endmodule

// File: hw/bank_tracker.sv
`timescale 1ns/1ps

module bank_tracker (
    input  logic                  ck_t,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  lpddr4_pkg::dec_cmd_t  cmd,
    output lpddr4_pkg::bank_map_t open_banks
);

    always_ff @(posedge ck_t) begin
        if (reset) begin
            open_banks <= '0;
        end else if (cmd_valid) begin
            case (cmd.kind)
                lpddr4_pkg::CMD_ACT: open_banks[cmd.bank] <= 1'b1;
                lpddr4_pkg::CMD_PRE: begin
                    if (cmd.all_banks) begin
                        open_banks <= '0;
                    end else begin
                        open_banks[cmd.bank] <= 1'b0;
                    end
                end
                lpddr4_pkg::CMD_WR,
                lpddr4_pkg::CMD_MWR,
                lpddr4_pkg::CMD_RD: begin
                    if (cmd.auto_pre) open_banks[cmd.bank] <= 1'b0; // closes after burst
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/mode_reg_shadow.sv
`timescale 1ns/1ps
`include "lpddr4_cfg.svh"

module mode_reg_shadow (
    input  logic                 ck_t,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  lpddr4_pkg::dec_cmd_t cmd,
    output lpddr4_pkg::mr_cfg_t  mr_cfg
);

    logic [`LPDDR4_MR_W-1:0] mr0;
    logic [`LPDDR4_MR_W-1:0] mr1;
    logic [`LPDDR4_MR_W-1:0] mr2;

    function automatic lpddr4_pkg::lat_t lat_calc(input logic [2:0] code);
        lat_calc = lpddr4_pkg::lat_t'(`LPDDR4_LAT_BASE + `LPDDR4_LAT_STEP * code);
    endfunction

    always_ff @(posedge ck_t) begin
        if (reset) begin
            mr0 <= '0;
            mr1 <= '0;
            mr2 <= '0;
        end else if (cmd_valid && cmd.kind == lpddr4_pkg::CMD_MRW) begin
            case (cmd.mr_addr)
                6'd0: mr0 <= cmd.mr_data;
                6'd1: mr1 <= cmd.mr_data;
                6'd2: mr2 <= cmd.mr_data;
                default: ; // other MRs not shadowed
            endcase
        end
    end

    always_comb begin
        mr_cfg.mr0           = mr0;
        mr_cfg.read_latency  = lat_calc(mr2[2:0]);
        mr_cfg.write_latency = lat_calc(mr2[5:3]);
        mr_cfg.wls           = mr2[6]; // write latency set B
        mr_cfg.wr_lev        = mr2[7];
        mr_cfg.burst_len     = mr1[1:0];
        mr_cfg.nwr           = lat_calc(mr1[6:4]);
    end

endmodule

// File: hw/lpddr4_cmd_decoder_top.sv
`timescale 1ns/1ps

module lpddr4_cmd_decoder_top (
    input  logic                  ck_t,
    input  logic                  reset,
    input  logic                  cs,
    input  lpddr4_pkg::ca_word_t  ca,
    output logic                  cmd_valid,
    output lpddr4_pkg::dec_cmd_t  cmd,
    output lpddr4_pkg::bank_map_t open_banks,
    output lpddr4_pkg::mr_cfg_t   mr_cfg
);

    logic                  frame_valid;
    lpddr4_pkg::ca_frame_t frame;

    // collects CA words, one frame per command
    ca_frame_capture u_ca_frame_capture (
        .ck_t        (ck_t),
        .reset       (reset),
        .cs          (cs),
        .ca          (ca),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    cmd_field_extract u_cmd_field_extract (
        .ck_t        (ck_t),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

    bank_tracker u_bank_tracker (
        .ck_t       (ck_t),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .open_banks (open_banks)
    );

    // MR0..MR2 shadow and timing
    mode_reg_shadow u_mode_reg_shadow (
        .ck_t      (ck_t),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .mr_cfg    (mr_cfg)
    );

endmodule

// File: bench/lpddr4_cmd_decoder_sva.sv
`timescale 1ns/1ps

module lpddr4_cmd_decoder_sva (
    input logic                  ck_t,
    input logic                  reset,
    input logic                  cmd_valid,
    input lpddr4_pkg::dec_cmd_t  cmd,
    input lpddr4_pkg::bank_map_t open_banks
);

    // sync reset, so low from the edge after reset
    valid_low_in_reset: assert property (@(posedge ck_t) reset |=> !cmd_valid)
        else $error("cmd_valid high during reset");

    valid_one_cycle: assert property (@(posedge ck_t) disable iff (reset)
        cmd_valid |=> !cmd_valid)
        else $error("cmd_valid high on two consecutive cycles");

    cmd_known: assert property (@(posedge ck_t) disable iff (reset)
        cmd_valid |-> !$isunknown(cmd))
        else $error("cmd has unknown bits while cmd_valid is high");

    banks_known: assert property (@(posedge ck_t) disable iff (reset)
        !$isunknown(open_banks))
        else $error("open_banks has unknown bits after reset");

endmodule

// File: bench/tb_lpddr4_cmd_decoder.sv
`timescale 1ns/1ps
`include "lpddr4_cfg.svh"

module tb_lpddr4_cmd_decoder;

    logic                  ck_t;
    logic                  reset;
    logic                  cs;
    lpddr4_pkg::ca_word_t  ca;
    logic                  cmd_valid;
    lpddr4_pkg::dec_cmd_t  cmd;
    lpddr4_pkg::bank_map_t open_banks;
    lpddr4_pkg::mr_cfg_t   mr_cfg;
    lpddr4_pkg::bank_map_t exp_banks; // reference model of open banks
    int                    cmd_count = 0;
    integer                seed = 32'h998b04c9;

    lpddr4_cmd_decoder_top u_lpddr4_cmd_decoder_top (.*);

    bind lpddr4_cmd_decoder_top lpddr4_cmd_decoder_sva u_lpddr4_cmd_decoder_sva (.*);

    initial ck_t = 1'b0;
    always #50 ck_t = ~ck_t;

    always @(posedge ck_t) begin
        if (!reset && cmd_valid) cmd_count <= cmd_count + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            abort_run($sformatf("FAIL %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    // CA0 carries the msb of the command code
    function automatic lpddr4_pkg::ca_word_t first_word(input logic [4:0] code, input logic ca5);
        return {ca5, code[0], code[1], code[2], code[3], code[4]};
    endfunction

    task automatic send_frame(input lpddr4_pkg::ca_word_t r1, r2, r3, r4, input int n);
        lpddr4_pkg::ca_word_t w [4];
        int i;
        w[0] = r1;
        w[1] = r2;
        w[2] = r3;
        w[3] = r4;
        for (i = 0; i < n; i++) begin
            @(posedge ck_t);
            cs <= (i == 0); // cs only with r1
            ca <= w[i];
        end
    endtask

    task automatic expect_cmd(input string name, input lpddr4_pkg::dec_cmd_t exp);
        int i;
        for (i = 0; i < 20; i++) begin
            @(negedge ck_t);
            if (cmd_valid) break;
        end
        if (!cmd_valid) begin
            abort_run($sformatf("timeout: no cmd_valid for %s within 20 cycles", name));
        end else begin
            check(name, exp, cmd);
        end
    endtask

    task automatic run_cmd(input string name, input lpddr4_pkg::ca_word_t r1, r2, r3, r4,
                           input int n, input lpddr4_pkg::dec_cmd_t exp);
        send_frame(r1, r2, r3, r4, n);
        expect_cmd(name, exp);
        @(negedge ck_t); // bank map moves on the cmd_valid edge
        check($sformatf("%s banks", name), exp_banks, open_banks);
    endtask

    task automatic activate(input string name, input lpddr4_pkg::bank_t b,
                            input lpddr4_pkg::row_t row);
        lpddr4_pkg::dec_cmd_t exp;
        exp      = '0;
        exp.kind = lpddr4_pkg::CMD_ACT;
        exp.bank = b;
        exp.row  = row;
        exp_banks[b] = 1'b1;
        run_cmd(name, {row[15:12], 2'b01}, {row[11:10], 1'b0, b}, {row[9:6], 2'b00},
                row[5:0], 4, exp);
    endtask

    task automatic precharge(input string name, input lpddr4_pkg::bank_t b, input logic ab);
        lpddr4_pkg::dec_cmd_t exp;
        exp           = '0;
        exp.kind      = lpddr4_pkg::CMD_PRE;
        exp.bank      = b;
        exp.all_banks = ab;
        if (ab) exp_banks = '0;
        else exp_banks[b] = 1'b0;
        run_cmd(name, first_word(5'b00001, ab), {3'b000, b}, '0, '0, 2, exp);
    endtask

    task automatic read_write(input string name, input logic [4:0] code,
                              input lpddr4_pkg::cmd_kind_t kind, input lpddr4_pkg::bank_t b,
                              input logic ap, input lpddr4_pkg::col_t col);
        lpddr4_pkg::dec_cmd_t exp;
        exp          = '0;
        exp.kind     = kind;
        exp.bank     = b;
        exp.auto_pre = ap;
        exp.column   = col;
        if (ap) exp_banks[b] = 1'b0; // auto-precharge closes the bank
        run_cmd(name, first_word(code, 1'b0), {ap, col[7], 1'b0, b}, {col[6], 5'b00000},
                col[5:0], 4, exp);
    endtask

    task automatic plain_cmd(input string name, input logic [4:0] code,
                             input lpddr4_pkg::cmd_kind_t kind, input logic ca5);
        lpddr4_pkg::dec_cmd_t exp;
        exp           = '0;
        exp.kind      = kind;
        exp.all_banks = (kind == lpddr4_pkg::CMD_REF) ? ca5 : 1'b0;
        run_cmd(name, first_word(code, ca5), '0, '0, '0, 2, exp);
    endtask

    task automatic mode_write(input string name, input lpddr4_pkg::mr_addr_t addr,
                              input lpddr4_pkg::mr_data_t data);
        lpddr4_pkg::dec_cmd_t exp;
        exp         = '0;
        exp.kind    = lpddr4_pkg::CMD_MRW;
        exp.mr_addr = addr;
        exp.mr_data = data;
        run_cmd(name, first_word(5'b01100, data[7]), addr, {data[6], 5'b00000}, data[5:0], 4, exp);
    endtask

    task automatic reset_values();
        @(negedge ck_t);
        check("reset cmd_valid", 0, cmd_valid);
        check("reset open_banks", 0, open_banks);
        check("reset read_latency", `LPDDR4_LAT_BASE, mr_cfg.read_latency);
        check("reset write_latency", `LPDDR4_LAT_BASE, mr_cfg.write_latency);
        check("reset wr_lev", 0, mr_cfg.wr_lev);
    endtask

    task automatic act_decode();
        activate("act bank 5", 3'd5, 16'ha5c3);
    endtask

    task automatic rw_auto_pre();
        activate("act bank 2", 3'd2, 16'h0f0f);
        read_write("wr no ap", 5'b00100, lpddr4_pkg::CMD_WR, 3'd2, 1'b0, 8'hb7);
        read_write("mwr ap", 5'b00110, lpddr4_pkg::CMD_MWR, 3'd5, 1'b1, 8'h4c);
        read_write("rd ap", 5'b01000, lpddr4_pkg::CMD_RD, 3'd2, 1'b1, 8'hff);
    endtask

    task automatic two_word_cmds();
        activate("act bank 1", 3'd1, 16'h1234);
        activate("act bank 3", 3'd3, 16'hfedc);
        activate("act bank 6", 3'd6, 16'h8001);
        precharge("pre bank 3", 3'd3, 1'b0);
        plain_cmd("ref all", 5'b00010, lpddr4_pkg::CMD_REF, 1'b1);
        plain_cmd("sre", 5'b00011, lpddr4_pkg::CMD_SRE, 1'b0);
        plain_cmd("srx", 5'b00101, lpddr4_pkg::CMD_SRX, 1'b0);
        plain_cmd("rfu", 5'b00111, lpddr4_pkg::CMD_RFU, 1'b0);
        precharge("pre all", 3'd0, 1'b1);
    endtask

    task automatic mode_reg_cmds();
        lpddr4_pkg::dec_cmd_t exp_a;
        lpddr4_pkg::dec_cmd_t exp_b;
        int start;
        mode_write("mrw mr2", 6'd2, 8'hdd); // RL code 5, WL code 3, wls and wr_lev set
        check("mr2 read_latency", `LPDDR4_LAT_BASE + `LPDDR4_LAT_STEP * 5, mr_cfg.read_latency);
        check("mr2 write_latency", `LPDDR4_LAT_BASE + `LPDDR4_LAT_STEP * 3, mr_cfg.write_latency);
        check("mr2 wls", 1, mr_cfg.wls);
        check("mr2 wr_lev", 1, mr_cfg.wr_lev);
        mode_write("mrw mr1", 6'd1, 8'h52); // BL code 2, nWR code 5
        check("mr1 burst_len", 2, mr_cfg.burst_len);
        check("mr1 nwr", `LPDDR4_LAT_BASE + `LPDDR4_LAT_STEP * 5, mr_cfg.nwr);
        mode_write("mrw mr0", 6'd0, 8'h6b);
        check("mr0 raw byte", 8'h6b, mr_cfg.mr0);
        exp_a         = '0;
        exp_a.kind    = lpddr4_pkg::CMD_MRR;
        exp_a.mr_addr = 6'd5;
        run_cmd("mrr", first_word(5'b01110, 1'b0), 6'd5, '0, '0, 4, exp_a);
        exp_a        = '0;
        exp_a.kind   = lpddr4_pkg::CMD_MPC;
        exp_a.mpc_op = 7'h21;
        exp_b        = exp_a;
        exp_b.mpc_op = 7'h41; // rd_fifo, four words
        start        = cmd_count;
        fork
            begin
                send_frame(first_word(5'b00000, 1'b0), 6'h21, '0, '0, 2);
                send_frame(first_word(5'b00000, 1'b1), 6'h01, 6'h15, 6'h2a, 4);
            end
            begin
                expect_cmd("mpc short", exp_a);
                expect_cmd("mpc rd_fifo", exp_b);
            end
        join
        repeat (4) @(negedge ck_t);
        check("mpc pulse count", 2, cmd_count - start);
    endtask

    task automatic random_act_pre();
        logic [31:0] r;
        int i;
        precharge("rand pre all", 3'd0, 1'b1);
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            if (r[0]) activate($sformatf("rand act %0d", i), r[3:1], r[21:6]);
            else precharge($sformatf("rand pre %0d", i), r[3:1], r[4] & r[5]);
        end
    endtask

    initial begin
        reset     = 1'b1;
        cs        = 1'b0;
        ca        = '0;
        exp_banks = '0;
        repeat (3) @(posedge ck_t);
        reset <= 1'b0;
        reset_values();
        act_decode();
        rw_auto_pre();
        two_word_cmds();
        mode_reg_cmds();
        random_act_pre();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/lpddr4_pkg.sv
ca_capture/ca_frame_capture.sv
hw/cmd_field_extract.sv
hw/bank_tracker.sv
hw/mode_reg_shadow.sv
hw/lpddr4_cmd_decoder_top.sv
bench/lpddr4_cmd_decoder_sva.sv
bench/tb_lpddr4_cmd_decoder.sv
